// File: Makefile
TOP := tb_rv_core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qxF "** PASS **" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/tb_rv_core.sv
`timescale 1ns/1ns
`include "rv_defs.svh"

module tb_rv_core;
    import rv_pkg::*;

    localparam int          PROG_LEN = `RV_EXIT_PC / 4; // words before the exit address
    localparam int          MAX_T    = 40;
    localparam logic [31:0] NOP      = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [6:0]  OP_LOAD  = 7'b0000011;
    localparam logic [6:0]  OP_STORE = 7'b0100011;
    localparam logic [6:0]  OP_REG   = 7'b0110011;
    localparam logic [6:0]  OP_IMM   = 7'b0010011;
    localparam logic [6:0]  OP_BR    = 7'b1100011;
    localparam logic [6:0]  OP_JAL   = 7'b1101111;
    localparam logic [6:0]  OP_JALR  = 7'b1100111;
    localparam logic [6:0]  OP_LUI   = 7'b0110111;
    localparam logic [6:0]  OP_AUIPC = 7'b0010111;
    localparam logic [4:0]  X0 = 5'd0;
    localparam logic [4:0]  X1 = 5'd1;
    localparam logic [4:0]  X2 = 5'd2;
    localparam logic [4:0]  GP = 5'd3;

    typedef struct packed {
        logic [31:0] gp;
        logic [31:0] mem_word;
        logic [5:0]  mem_idx;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_inst;
    dmem_req_t   dmem_req;
    logic [31:0] dmem_rdata;
    logic [31:0] gp;
    logic        exit_w;

    logic [31:0] imem [32];
    logic [31:0] dmem [64];

    string       t_name [MAX_T];
    logic [31:0] t_prog [MAX_T][PROG_LEN];
    expect_t     t_exp  [MAX_T];
    int          n_tests;
    logic [31:0] buf_w  [PROG_LEN]; // program under construction
    int          buf_len;
    logic [31:0] lcg_state;
    int          cycles = 0;
    int          limit;
    int          errs;
    int          passed;

    rv_core u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_inst_i  (imem_inst),
        .dmem_req_o   (dmem_req),
        .dmem_rdata_i (dmem_rdata),
        .gp_o         (gp),
        .exit_o       (exit_w)
    );

    assign imem_inst  = imem[imem_addr[6:2]];
    assign dmem_rdata = dmem[dmem_req.addr[7:2]];

    always @(posedge clk) begin
        if (dmem_req.wen) begin
            dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: core did not reach the exit address within %0d cycles", limit);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] fill_word(logic [5:0] idx);
        return {10'h2a5, idx, 10'h0c3, idx};
    endfunction

    function automatic logic [31:0] enc_i(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                          logic [11:0] imm, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] enc_s(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BR};
    endfunction

    function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic logic [31:0] sra_ref(logic [31:0] v, logic [4:0] sh);
        return (v >> sh) | (v[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
    endfunction

    function automatic logic br_rule(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        if (buf_len < PROG_LEN) begin
            buf_w[buf_len] = word;
        end
        buf_len++;
    endtask

    task automatic add_test_mem(input string name, input logic [31:0] exp_gp,
                                input logic [5:0] idx, input logic [31:0] word);
        assert (buf_len <= PROG_LEN) else begin
            $display("program for %s is too long for the instruction memory", name);
            errs++;
        end
        t_name[n_tests] = name;
        for (int i = 0; i < PROG_LEN; i++) begin
            t_prog[n_tests][i] = (i < buf_len) ? buf_w[i] : NOP; // nop padding
        end
        t_exp[n_tests] = {exp_gp, word, idx};
        n_tests++;
        buf_len = 0;
    endtask

    task automatic add_test(input string name, input logic [31:0] exp_gp);
        add_test_mem(name, exp_gp, 6'd63, fill_word(6'd63)); // untouched word
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800; // round up for the sign-extended low part
        emit({hi[31:12], rd, OP_LUI});
        emit(enc_i(3'd0, rd, rd, v[11:0], OP_IMM));
    endtask

    task automatic rr_test(input string name, input logic [6:0] f7, input logic [2:0] f3,
                           input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp);
        load_const(X1, a);
        load_const(X2, b);
        emit(enc_r(f7, f3, GP, X1, X2));
        add_test(name, exp);
    endtask

    task automatic imm_test(input string name, input logic [2:0] f3, input logic [31:0] a,
                            input logic [11:0] imm, input logic [31:0] exp);
        load_const(X1, a);
        emit(enc_i(f3, GP, X1, imm, OP_IMM));
        add_test(name, exp);
    endtask

    task automatic br_test(input string name, input logic [2:0] f3,
                           input logic [31:0] a, input logic [31:0] b);
        load_const(X1, a);
        load_const(X2, b);
        emit(enc_i(3'd0, GP, X0, 12'd1, OP_IMM));
        emit(enc_b(f3, X1, X2, 13'd8)); // skips the next addi when taken
        emit(enc_i(3'd0, GP, X0, 12'd2, OP_IMM));
        add_test(name, br_rule(f3, a, b) ? 32'd1 : 32'd2);
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [31:0] ea;
        logic [4:0]  sh;
        logic [11:0] imm;
        a   = lcg_next();
        b   = lcg_next();
        imm = b[11:0];
        emit({a[31:12], GP, OP_LUI});
        add_test("lui", {a[31:12], 12'd0});
        load_const(X1, a);
        emit(enc_i(3'd0, GP, X1, imm, OP_IMM));
        add_test("addi", a + {{20{imm[11]}}, imm});
        rr_test("add", 7'h00, 3'd0, a, b, a + b);
        rr_test("sub", 7'h20, 3'd0, a, b, a - b);
        rr_test("and", 7'h00, 3'd7, a, b, a & b);
        rr_test("or", 7'h00, 3'd6, a, b, a | b);
        rr_test("xor", 7'h00, 3'd4, a, b, a ^ b);

        v  = lcg_next() | 32'h8000_0001; // both ends set
        b  = lcg_next();                 // upper bits of rs2 must be ignored
        sh = b[4:0];
        rr_test("sll", 7'h00, 3'd1, v, b, v << sh);
        rr_test("srl", 7'h00, 3'd5, v, b, v >> sh);
        rr_test("sra", 7'h20, 3'd5, v, b, sra_ref(v, sh));
        sh = ~sh;
        imm_test("slli", 3'd1, v, {7'h00, sh}, v << sh);
        imm_test("srli", 3'd5, v, {7'h00, sh}, v >> sh);
        imm_test("srai", 3'd5, v, {7'h20, sh}, sra_ref(v, sh));
        a = 32'h8000_0000;
        b = 32'h7fff_ffff;
        rr_test("slt", 7'h00, 3'd2, a, b, 32'd1);  // most negative < most positive
        rr_test("sltu", 7'h00, 3'd3, a, b, 32'd0); // 0x80000000 is the larger unsigned
        imm_test("slti", 3'd2, 32'hffff_ffff, 12'd0, 32'd1);   // -1 < 0
        imm_test("sltiu", 3'd3, 32'd1, 12'hfff, 32'd1);        // imm reads as all ones

        v  = lcg_next();
        ea = 32'h80 + {{20{1'b1}}, 12'hff8}; // base 0x80, offset -8
        load_const(X1, v);
        emit(enc_i(3'd0, X2, X0, 12'h080, OP_IMM));
        emit(enc_s(X2, X1, 12'hff8));
        emit(enc_i(3'd2, GP, X2, 12'hff8, OP_LOAD));
        add_test_mem("sw_lw", v, ea[7:2], v);
        emit(enc_i(3'd0, X2, X0, 12'h020, OP_IMM));
        emit(enc_i(3'd2, GP, X2, 12'h004, OP_LOAD));
        add_test("lw_fill", fill_word(6'd9)); // address 0x24

        br_test("beq_taken", 3'd0, 32'd1, 32'd1);
        br_test("beq_not", 3'd0, 32'hffff_ffff, 32'd1);
        br_test("bne_taken", 3'd1, 32'hffff_ffff, 32'd1);
        br_test("bne_not", 3'd1, 32'd1, 32'd1);
        br_test("blt_taken", 3'd4, 32'hffff_ffff, 32'd1);
        br_test("blt_not", 3'd4, 32'd1, 32'hffff_ffff);
        br_test("bge_taken", 3'd5, 32'd1, 32'hffff_ffff);
        br_test("bge_not", 3'd5, 32'hffff_ffff, 32'd1);
        br_test("bltu_taken", 3'd6, 32'd1, 32'hffff_ffff);
        br_test("bltu_not", 3'd6, 32'hffff_ffff, 32'd1);
        br_test("bgeu_taken", 3'd7, 32'hffff_ffff, 32'd1);
        br_test("bgeu_not", 3'd7, 32'd1, 32'hffff_ffff);

        emit(NOP);
        emit(enc_j(GP, 21'd8)); // at 0x4, lands on 0xc
        emit(enc_i(3'd0, GP, X0, 12'd5, OP_IMM));
        emit(enc_i(3'd0, GP, GP, 12'd100, OP_IMM));
        add_test("jal", 32'd8 + 32'd100);
        emit(enc_i(3'd0, X1, X0, 12'd17, OP_IMM));
        emit(enc_i(3'd0, GP, X1, 12'd4, OP_JALR)); // 21 with bit 0 cleared
        repeat (3) emit(enc_i(3'd0, GP, X0, 12'd5, OP_IMM));
        emit(enc_i(3'd0, GP, GP, 12'd100, OP_IMM));
        add_test("jalr", 32'd8 + 32'd100);
        a = lcg_next();
        emit(NOP);
        emit(NOP);
        emit({a[31:12], GP, OP_AUIPC});
        add_test("auipc", {a[31:12], 12'd0} + 32'd8);
        emit(enc_i(3'd0, GP, X0, 12'd77, OP_IMM));
        emit(enc_i(3'd0, X0, X0, 12'd55, OP_IMM));
        emit(enc_r(7'h00, 3'd0, GP, X0, X0));
        add_test("x0_halt", 32'd0);
    endtask

    task automatic run_test(input int t);
        int          bad;
        int          changed;
        logic [31:0] gp_snap;
        logic [31:0] exp_w;
        logic [31:0] dmem_snap [64];
        bad     = 0;
        changed = 0;
        @(posedge clk);
        rst_n <= 1'b0;
        for (int i = 0; i < 32; i++) begin
            imem[i] = NOP;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            imem[i] = t_prog[t][i];
        end
        // whatever sits at the exit address must never commit
        imem[PROG_LEN] = t[0] ? enc_s(X0, GP, 12'd0) : enc_i(3'd0, GP, GP, 12'd1, OP_IMM);
        for (int i = 0; i < 64; i++) begin
            dmem[i] <= fill_word(i[5:0]);
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        do begin
            @(negedge clk);
        end while (!exit_w);

        assert (imem_addr == `RV_EXIT_PC) else begin
            $display("mismatch %s: pc at exit expected %h, actual %h", t_name[t],
                     `RV_EXIT_PC, imem_addr);
            bad++;
        end
        assert (gp == t_exp[t].gp) else begin
            $display("mismatch %s: gp expected %h, actual %h", t_name[t], t_exp[t].gp, gp);
            bad++;
        end
        // every word keeps its fill pattern except the one the test stores
        for (int i = 0; i < 64; i++) begin
            exp_w = (i == t_exp[t].mem_idx) ? t_exp[t].mem_word : fill_word(i[5:0]);
            assert (dmem[i] == exp_w) else begin
                $display("mismatch %s: dmem[%0d] expected %h, actual %h", t_name[t],
                         i, exp_w, dmem[i]);
                bad++;
            end
        end
        gp_snap = gp;
        for (int i = 0; i < 64; i++) begin
            dmem_snap[i] = dmem[i];
        end
        repeat (10) @(negedge clk);
        for (int i = 0; i < 64; i++) begin
            if (dmem[i] != dmem_snap[i]) changed++;
        end
        assert (exit_w && gp == gp_snap && changed == 0) else begin
            $display("%s: state changed after the core halted (%0d memory words)",
                     t_name[t], changed);
            bad++;
        end

        if (bad == 0) begin
            passed++;
            $display("test %0d %s: ok", t, t_name[t]);
        end else begin
            $display("test %0d %s: %0d errors", t, t_name[t], bad);
        end
        errs += bad;
    endtask

    initial begin
        rst_n    <= 1'b0;
        lcg_state = 32'h20c8_34d8;
        n_tests   = 0;
        buf_len   = 0;
        limit     = 0;
        errs      = 0;
        passed    = 0;
        for (int i = 0; i < 32; i++) begin
            imem[i] = NOP;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] <= fill_word(i[5:0]);
        end
        build_table();
        limit = n_tests * (5 + 40);
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", n_tests, passed,
                 n_tests - passed, errs);
        if (errs == 0 && passed == n_tests) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+src
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_core.sv
sim/tb_rv_core.sv

// File: src/rv_alu.sv
`timescale 1ns/1ns
`include "rv_defs.svh"

module rv_alu (
    input  rv_pkg::alu_fn_e     fn_i,
    input  logic [`RV_XLEN-1:0] op1_i,
    input  logic [`RV_XLEN-1:0] op2_i,
    output logic [`RV_XLEN-1:0] result_o,
    output logic                br_taken_o
);
    import rv_pkg::*;

    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] sum;
    logic                eq;
    logic                lt_s;
    logic                lt_u;

    assign shamt = op2_i[4:0];
    assign sum   = op1_i + op2_i;
    assign eq    = (op1_i == op2_i);
    assign lt_s  = ($signed(op1_i) < $signed(op2_i));
    assign lt_u  = (op1_i < op2_i);

    always_comb begin
        case (fn_i)
            ALU_ADD:  result_o = sum;
            ALU_SUB:  result_o = op1_i - op2_i;
            ALU_AND:  result_o = op1_i & op2_i;
            ALU_OR:   result_o = op1_i | op2_i;
            ALU_XOR:  result_o = op1_i ^ op2_i;
            ALU_SLL:  result_o = op1_i << shamt;
            ALU_SRL:  result_o = op1_i >> shamt;
            ALU_SRA:  result_o = $unsigned($signed(op1_i) >>> shamt);
            ALU_SLT:  result_o = {{(`RV_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result_o = {{(`RV_XLEN-1){1'b0}}, lt_u};
            ALU_JALR: result_o = {sum[`RV_XLEN-1:1], 1'b0};
            default:  result_o = '0; // branch compares produce no result
        endcase
    end

    // bge/bgeu take the branch when not less-than
    always_comb begin
        case (fn_i)
            BR_BEQ:  br_taken_o = eq;
            BR_BNE:  br_taken_o = !eq;
            BR_BLT:  br_taken_o = lt_s;
            BR_BGE:  br_taken_o = !lt_s;
            BR_BLTU: br_taken_o = lt_u;
            BR_BGEU: br_taken_o = !lt_u;
            default: br_taken_o = 1'b0;
        endcase
    end

endmodule

// File: src/rv_core.sv
`timescale 1ns/1ns
`include "rv_defs.svh"

module rv_core (
    input  logic                clk,
    input  logic                rst_n,
    output logic [`RV_XLEN-1:0] imem_addr_o,
    input  logic [`RV_XLEN-1:0] imem_inst_i,
    output rv_pkg::dmem_req_t   dmem_req_o,
    input  logic [`RV_XLEN-1:0] dmem_rdata_i,
    output logic [`RV_XLEN-1:0] gp_o,
    output logic                exit_o
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] pc_next;
    dec_t                dec;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] op1;
    logic [`RV_XLEN-1:0] op2;
    logic [`RV_XLEN-1:0] alu_result;
    logic                br_taken;
    logic [`RV_XLEN-1:0] wb_data;
    logic                halt;
    logic                rf_wen;

    assign imem_addr_o = pc;
    assign pc_plus4    = pc + `RV_XLEN'd4;
    assign halt        = (pc == `RV_EXIT_PC);
    assign exit_o      = halt;

    rv_decoder u_decoder (
        .inst_i (imem_inst_i),
        .dec_o  (dec)
    );

    assign rf_wen = dec.ctrl.rf_wen && !halt; // no commit once halted

    rv_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_i      (dec.rs1),
        .rs2_i      (dec.rs2),
        .rd_i       (dec.rd),
        .wen_i      (rf_wen),
        .wdata_i    (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .gp_o       (gp_o)
    );

    always_comb begin
        case (dec.ctrl.op1_sel)
            OP1_RS1: op1 = rs1_data;
            OP1_PC:  op1 = pc;
            default: op1 = '0;
        endcase
    end

    assign op2 = (dec.ctrl.op2_sel == OP2_IMM) ? dec.imm : rs2_data;

    rv_alu u_alu (
        .fn_i       (dec.ctrl.alu_fn),
        .op1_i      (op1),
        .op2_i      (op2),
        .result_o   (alu_result),
        .br_taken_o (br_taken)
    );

    always_comb begin
        case (dec.ctrl.wb_sel)
            WB_MEM:  wb_data = dmem_rdata_i;
            WB_PC:   wb_data = pc_plus4;
            default: wb_data = alu_result;
        endcase
    end

    assign dmem_req_o.addr  = alu_result;
    assign dmem_req_o.wdata = rs2_data;
    assign dmem_req_o.wen   = dec.ctrl.mem_wen && !halt && rst_n;

    // branch first, then jump target from the ALU
    assign pc_next = br_taken      ? pc + dec.br_off :
                     dec.ctrl.jump ? alu_result :
                                     pc_plus4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!halt) begin
            pc <= pc_next;
        end
    end

    // catches a jalr target with bit 1 set
    assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("pc not word-aligned: %h", pc);

endmodule

// File: src/rv_decoder.sv
`timescale 1ns/1ns
`include "rv_defs.svh"

module rv_decoder (
    input  logic [`RV_XLEN-1:0] inst_i,
    output rv_pkg::dec_t        dec_o
);
    import rv_pkg::*;

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm;
    ctrl_t               ctrl;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};

    always_comb begin
        // unknown encodings fall through as a nop
        ctrl.alu_fn  = ALU_ADD;
        ctrl.op1_sel = OP1_RS1;
        ctrl.op2_sel = OP2_RS2;
        ctrl.mem_wen = 1'b0;
        ctrl.rf_wen  = 1'b0;
        ctrl.wb_sel  = WB_ALU;
        ctrl.jump    = 1'b0;
        imm          = imm_i;

        case (opcode)
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin // lw
                    ctrl.op2_sel = OP2_IMM;
                    ctrl.rf_wen  = 1'b1;
                    ctrl.wb_sel  = WB_MEM;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin // sw
                    ctrl.op2_sel = OP2_IMM;
                    ctrl.mem_wen = 1'b1;
                    imm          = imm_s;
                end
            end
            OPC_OP: begin
                ctrl.rf_wen = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_fn = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl.alu_fn = ALU_SUB;
                    {7'b0000000, 3'b001}: ctrl.alu_fn = ALU_SLL;
                    {7'b0000000, 3'b010}: ctrl.alu_fn = ALU_SLT;
                    {7'b0000000, 3'b011}: ctrl.alu_fn = ALU_SLTU;
                    {7'b0000000, 3'b100}: ctrl.alu_fn = ALU_XOR;
                    {7'b0000000, 3'b101}: ctrl.alu_fn = ALU_SRL;
                    {7'b0100000, 3'b101}: ctrl.alu_fn = ALU_SRA;
                    {7'b0000000, 3'b110}: ctrl.alu_fn = ALU_OR;
                    {7'b0000000, 3'b111}: ctrl.alu_fn = ALU_AND;
                    default:              ctrl.rf_wen = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                ctrl.op2_sel = OP2_IMM;
                ctrl.rf_wen  = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_fn = ALU_ADD;
                    3'b010: ctrl.alu_fn = ALU_SLT;
                    3'b011: ctrl.alu_fn = ALU_SLTU;
                    3'b100: ctrl.alu_fn = ALU_XOR;
                    3'b110: ctrl.alu_fn = ALU_OR;
                    3'b111: ctrl.alu_fn = ALU_AND;
                    3'b001: begin
                        ctrl.alu_fn = ALU_SLL;
                        ctrl.rf_wen = (funct7 == 7'b0000000);
                    end
                    default: begin // srli / srai share funct3
                        ctrl.alu_fn = funct7[5] ? ALU_SRA : ALU_SRL;
                        ctrl.rf_wen = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    end
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  ctrl.alu_fn = BR_BEQ;
                    3'b001:  ctrl.alu_fn = BR_BNE;
                    3'b100:  ctrl.alu_fn = BR_BLT;
                    3'b101:  ctrl.alu_fn = BR_BGE;
                    3'b110:  ctrl.alu_fn = BR_BLTU;
                    3'b111:  ctrl.alu_fn = BR_BGEU;
                    default: ctrl.alu_fn = ALU_ADD;
                endcase
            end
            OPC_JAL: begin
                ctrl.op1_sel = OP1_PC;
                ctrl.op2_sel = OP2_IMM;
                ctrl.rf_wen  = 1'b1;
                ctrl.wb_sel  = WB_PC;
                ctrl.jump    = 1'b1;
                imm          = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl.alu_fn  = ALU_JALR;
                    ctrl.op2_sel = OP2_IMM;
                    ctrl.rf_wen  = 1'b1;
                    ctrl.wb_sel  = WB_PC;
                    ctrl.jump    = 1'b1;
                end
            end
            OPC_LUI: begin
                ctrl.op1_sel = OP1_ZERO;
                ctrl.op2_sel = OP2_IMM;
                ctrl.rf_wen  = 1'b1;
                imm          = imm_u;
            end
            OPC_AUIPC: begin
                ctrl.op1_sel = OP1_PC;
                ctrl.op2_sel = OP2_IMM;
                ctrl.rf_wen  = 1'b1;
                imm          = imm_u;
            end
            default: ;
        endcase
    end

    assign dec_o.rs1    = inst_i[19:15];
    assign dec_o.rs2    = inst_i[24:20];
    assign dec_o.rd     = inst_i[11:7];
    assign dec_o.ctrl   = ctrl;
    assign dec_o.imm    = imm;
    assign dec_o.br_off = imm_b;

    // a store never writes back
    always_comb begin
        assert (!(ctrl.mem_wen && ctrl.rf_wen))
            else $error("decoder set both mem_wen and rf_wen for %h", inst_i);
    end

endmodule

// File: src/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data word width
`define RV_XLEN     32

// register file shape
`define RV_NREGS    32
`define RV_REG_AW   5

// the core halts when the fetch address reaches this value
`define RV_EXIT_PC  32'h44

`endif

// File: src/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    // major opcodes used by the core
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_AND  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_XOR  = 5'd4,
        ALU_SLL  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,
        ALU_SLT  = 5'd8,
        ALU_SLTU = 5'd9,
        ALU_JALR = 5'd10, // add, then clear bit 0
        BR_BEQ   = 5'd11,
        BR_BNE   = 5'd12,
        BR_BLT   = 5'd13,
        BR_BGE   = 5'd14,
        BR_BLTU  = 5'd15,
        BR_BGEU  = 5'd16
    } alu_fn_e;

    typedef enum logic [1:0] {
        OP1_RS1  = 2'd0,
        OP1_PC   = 2'd1,
        OP1_ZERO = 2'd2  // lui
    } op1_sel_e;

    typedef enum logic {
        OP2_RS2 = 1'b0,
        OP2_IMM = 1'b1
    } op2_sel_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC  = 2'd2   // link address
    } wb_sel_e;

    typedef struct packed {
        alu_fn_e  alu_fn;
        op1_sel_e op1_sel;
        op2_sel_e op2_sel;
        logic     mem_wen;
        logic     rf_wen;
        wb_sel_e  wb_sel;
        logic     jump;
    } ctrl_t;

    typedef struct packed {
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
        ctrl_t                 ctrl;
        logic [`RV_XLEN-1:0]   imm;    // operand immediate
        logic [`RV_XLEN-1:0]   br_off; // sign-extended B offset
    } dec_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] wdata;
        logic                wen;
    } dmem_req_t;

endpackage

// File: src/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_defs.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`RV_REG_AW-1:0] rs1_i,
    input  logic [`RV_REG_AW-1:0] rs2_i,
    input  logic [`RV_REG_AW-1:0] rd_i,
    input  logic                  wen_i,
    input  logic [`RV_XLEN-1:0]   wdata_i,
    output logic [`RV_XLEN-1:0]   rs1_data_o,
    output logic [`RV_XLEN-1:0]   rs2_data_o,
    output logic [`RV_XLEN-1:0]   gp_o
);

    // x0 has no storage
    logic [`RV_NREGS-1:1][`RV_XLEN-1:0] regs;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (wen_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];
    assign gp_o       = regs[3]; // x3 tap

    // a write aimed at x0 must not land in any real register
    assert property (@(posedge clk) disable iff (!rst_n)
        (wen_i && rd_i == '0) |=> $stable(regs))
        else $error("write to x0 changed the register file");

endmodule
